//--- verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int PORT_WIDTH         = 32;                    // Data port, one word
    localparam int PORT_BYTES         = PORT_WIDTH / 8;
    localparam int INDEX_BITS_DEFAULT = 4;                     // 16 lines
    localparam int TAG_BITS           = PORT_WIDTH - INDEX_BITS_DEFAULT - 2;

    // Access size of a store, DOUBLE_WORD is served as WORD
    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD,
        DOUBLE_WORD
    } mem_op_width_t;

    // Cache address, seen as a plain word or split into its fields
    typedef union packed {
        logic [PORT_WIDTH - 1:0] raw;
        struct packed {
            logic [TAG_BITS - 1:0]           tag;
            logic [INDEX_BITS_DEFAULT - 1:0] index;
            logic [1:0]                      byte_sel;   // Byte inside the word
        } fields;
    } data_cache_addr_t;

    // Array write enables
    typedef struct packed {
        logic tag;
        logic data;
        logic dirty;
        logic valid;
    } data_cache_enable_t;

endpackage : dcache_pkg

`default_nettype wire

//--- verilog/dcache_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dcache_port_if;
    import dcache_pkg::*;

    logic                    read;          // Start of a lookup
    logic                    write;         // Single cycle write strobe
    data_cache_addr_t        address;
    logic [PORT_BYTES - 1:0] byte_write;    // Byte lanes to update
    logic [PORT_WIDTH - 1:0] data;
    logic                    dirty;
    logic                    valid;
    data_cache_enable_t      enable;        // Fields touched by a write

    logic                    hit;           // Result of the previous read
    logic                    port_free;     // Low while a fill owns the arrays

    modport ctrl (
        output read, write, address, byte_write, data, dirty, valid, enable,
        input  hit, port_free
    );

    modport array (
        input  read, write, address, byte_write, data, dirty, valid, enable,
        output hit, port_free
    );

endinterface : dcache_port_if

`default_nettype wire

//--- verilog/store_cache_control.sv
`timescale 1ns/1ns
`default_nettype none

module store_cache_control (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  logic                                inval_req_i,
    input  dcache_pkg::data_cache_addr_t        inval_addr_i,
    output logic                                inval_ack_o,

    input  logic                                store_req_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] store_data_i,
    input  dcache_pkg::data_cache_addr_t        store_addr_i,
    input  dcache_pkg::mem_op_width_t           store_width_i,

    dcache_port_if.ctrl                         cache,

    input  logic                                buf_free_i,
    output logic                                buf_push_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] buf_addr_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] buf_data_o,
    output dcache_pkg::mem_op_width_t           buf_width_o,

    output logic                                done_o,
    output logic                                idle_o
);
    import dcache_pkg::*;

    localparam logic [2:0] S_IDLE         = 3'd0;
    localparam logic [2:0] S_COMPARE_TAG  = 3'd1;
    localparam logic [2:0] S_WRITE_DATA   = 3'd2;
    localparam logic [2:0] S_MEMORY_WRITE = 3'd3;
    localparam logic [2:0] S_INVALIDATE   = 3'd4;

    logic [2:0]              state_q, state_d;
    logic                    inval_q, inval_d;     // Current job is an invalidation
    logic [PORT_BYTES - 1:0] lane_mask;
    logic [PORT_WIDTH - 1:0] lane_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            inval_q <= 1'b0;
        end else begin
            state_q <= state_d;
            inval_q <= inval_d;
        end
    end

    assign idle_o = (state_q == S_IDLE);

    // Missed stores go to the buffer unchanged
    assign buf_addr_o  = store_addr_i.raw;
    assign buf_data_o  = store_data_i;
    assign buf_width_o = store_width_i;

    // Place the store operand on its byte lanes
    always_comb begin : store_align
        case (store_width_i)
            BYTE: begin
                lane_mask = PORT_BYTES'(1) << store_addr_i.fields.byte_sel;
                lane_data = {PORT_BYTES{store_data_i[7:0]}};
            end
            HALF_WORD: begin
                lane_mask = store_addr_i.fields.byte_sel[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{store_data_i[15:0]}};
            end
            default: begin                                   // WORD and DOUBLE_WORD
                lane_mask = '1;
                lane_data = store_data_i;
            end
        endcase
    end : store_align

    always_comb begin : fsm_logic
        state_d     = state_q;
        inval_d     = inval_q;
        done_o      = 1'b0;
        inval_ack_o = 1'b0;
        buf_push_o  = 1'b0;

        cache.read       = 1'b0;
        cache.write      = 1'b0;
        cache.address    = '0;
        cache.byte_write = '0;
        cache.data       = '0;
        cache.dirty      = 1'b0;
        cache.valid      = 1'b0;
        cache.enable     = '0;

        case (state_q)
            S_IDLE: begin
                if (cache.port_free && inval_req_i) begin      // Invalidation first
                    state_d       = S_COMPARE_TAG;
                    inval_d       = 1'b1;
                    inval_ack_o   = 1'b1;
                    cache.read    = 1'b1;
                    cache.address = inval_addr_i;
                end else if (cache.port_free && store_req_i) begin
                    state_d       = S_COMPARE_TAG;
                    inval_d       = 1'b0;
                    cache.read    = 1'b1;
                    cache.address = store_addr_i;
                end
            end

            S_COMPARE_TAG: begin
                if (inval_q) begin
                    cache.address = inval_addr_i;
                    if (cache.hit) begin
                        state_d = S_INVALIDATE;
                    end else begin
                        state_d = S_IDLE;                      // Line not present
                        done_o  = 1'b1;
                    end
                end else begin
                    cache.address = store_addr_i;
                    state_d = cache.hit ? S_WRITE_DATA : S_MEMORY_WRITE;
                end
            end

            S_WRITE_DATA: begin
                cache.address = store_addr_i;
                if (cache.port_free) begin
                    cache.write        = 1'b1;
                    cache.byte_write   = lane_mask;
                    cache.data         = lane_data;
                    cache.dirty        = 1'b1;
                    cache.enable.data  = 1'b1;
                    cache.enable.dirty = 1'b1;
                    done_o  = 1'b1;
                    state_d = S_IDLE;
                end
            end

            S_MEMORY_WRITE: begin
                if (buf_free_i) begin                          // Hold on a full buffer
                    buf_push_o = 1'b1;
                    done_o     = 1'b1;
                    state_d    = S_IDLE;
                end
            end

            S_INVALIDATE: begin
                cache.address = inval_addr_i;
                if (cache.port_free) begin
                    cache.write        = 1'b1;
                    cache.valid        = 1'b0;
                    cache.enable.valid = 1'b1;
                    done_o  = 1'b1;
                    state_d = S_IDLE;
                end
            end

            default: begin
                state_d = S_IDLE;
            end
        endcase
    end : fsm_logic

endmodule : store_cache_control

`default_nettype wire

//--- verilog/dcache_arrays.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_arrays #(
    parameter int INDEX_BITS = dcache_pkg::INDEX_BITS_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    dcache_port_if.array                        cache,

    input  logic                                fill_i,
    input  dcache_pkg::data_cache_addr_t        fill_addr_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] fill_data_i,

    input  dcache_pkg::data_cache_addr_t        load_addr_i,
    output logic                                load_hit_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] load_data_o
);
    import dcache_pkg::*;

    localparam int LINES  = 2 ** INDEX_BITS;
    localparam int TAG_W  = PORT_WIDTH - INDEX_BITS - 2;

    logic [TAG_W - 1:0]      tag_mem   [LINES];
    logic [PORT_WIDTH - 1:0] data_mem  [LINES];
    logic [LINES - 1:0]      dirty_mem;
    logic [LINES - 1:0]      valid_q;

    logic [INDEX_BITS - 1:0] rd_index, rd_index_q, wr_index, fill_index, load_index;
    logic [TAG_W - 1:0]      rd_tag, rd_tag_q, wr_tag, fill_tag, load_tag;

    // Only the configured index bits take part
    assign rd_index   = cache.address.raw[INDEX_BITS + 1:2];
    assign rd_tag     = cache.address.raw[PORT_WIDTH - 1:INDEX_BITS + 2];
    assign wr_index   = rd_index;                            // Same address lines
    assign wr_tag     = rd_tag;
    assign fill_index = fill_addr_i.raw[INDEX_BITS + 1:2];
    assign fill_tag   = fill_addr_i.raw[PORT_WIDTH - 1:INDEX_BITS + 2];
    assign load_index = load_addr_i.raw[INDEX_BITS + 1:2];
    assign load_tag   = load_addr_i.raw[PORT_WIDTH - 1:INDEX_BITS + 2];

    assign cache.port_free = !fill_i;                        // Fill owns the arrays

    always_ff @(posedge clk_i) begin
        if (cache.read) begin
            rd_index_q <= rd_index;
            rd_tag_q   <= rd_tag;
        end
    end

    assign cache.hit = valid_q[rd_index_q] && (tag_mem[rd_index_q] == rd_tag_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index] <= 1'b1;
        end else if (cache.write && cache.enable.valid) begin
            valid_q[wr_index] <= cache.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_mem[fill_index]   <= fill_tag;
            data_mem[fill_index]  <= fill_data_i;
            dirty_mem[fill_index] <= 1'b0;                   // Installed clean
        end else if (cache.write) begin
            if (cache.enable.tag) begin
                tag_mem[wr_index] <= wr_tag;
            end
            if (cache.enable.dirty) begin
                dirty_mem[wr_index] <= cache.dirty;
            end
            if (cache.enable.data) begin
                for (int b = 0; b < PORT_BYTES; b++) begin
                    if (cache.byte_write[b]) begin
                        data_mem[wr_index][8 * b +: 8] <= cache.data[8 * b +: 8];
                    end
                end
            end
        end
    end

    // Load port, one cycle latency
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_hit_o <= 1'b0;
        end else begin
            load_hit_o <= valid_q[load_index] && (tag_mem[load_index] == load_tag);
        end
    end

    always_ff @(posedge clk_i) begin
        load_data_o <= data_mem[load_index];
    end

endmodule : dcache_arrays

`default_nettype wire

//--- verilog/store_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module store_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  logic                                push_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] addr_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] data_i,
    input  dcache_pkg::mem_op_width_t           width_i,
    output logic                                free_o,

    output logic                                mem_req_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] mem_addr_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] mem_data_o,
    output dcache_pkg::mem_op_width_t           mem_width_o,
    input  logic                                mem_ack_i
);
    import dcache_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [PORT_WIDTH - 1:0] addr_mem  [DEPTH];
    logic [PORT_WIDTH - 1:0] data_mem  [DEPTH];
    mem_op_width_t           width_mem [DEPTH];

    logic [PTR_BITS - 1:0]   wr_ptr_q, rd_ptr_q;
    logic [PTR_BITS:0]       count_q;
    logic                    push, pop;

    assign free_o    = (count_q != (PTR_BITS + 1)'(DEPTH));
    assign mem_req_o = (count_q != '0);
    assign push      = push_i && free_o;
    assign pop       = mem_req_o && mem_ack_i;

    // Head entry, held until popped
    assign mem_addr_o  = addr_mem[rd_ptr_q];
    assign mem_data_o  = data_mem[rd_ptr_q];
    assign mem_width_o = width_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q]  <= addr_i;
            data_mem[wr_ptr_q]  <= data_i;
            width_mem[wr_ptr_q] <= width_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule : store_buffer

`default_nettype wire

//--- verilog/store_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module store_subsystem_top #(
    parameter int INDEX_BITS = dcache_pkg::INDEX_BITS_DEFAULT,
    parameter int BUF_DEPTH  = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  logic                                inval_req_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] inval_addr_i,
    output logic                                inval_ack_o,

    input  logic                                store_req_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] store_data_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] store_addr_i,
    input  dcache_pkg::mem_op_width_t           store_width_i,
    output logic                                done_o,
    output logic                                idle_o,

    input  logic                                fill_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] fill_addr_i,
    input  logic [dcache_pkg::PORT_WIDTH - 1:0] fill_data_i,

    input  logic [dcache_pkg::PORT_WIDTH - 1:0] load_addr_i,
    output logic                                load_hit_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] load_data_o,

    output logic                                mem_req_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] mem_addr_o,
    output logic [dcache_pkg::PORT_WIDTH - 1:0] mem_data_o,
    output dcache_pkg::mem_op_width_t           mem_width_o,
    input  logic                                mem_ack_i
);
    import dcache_pkg::*;

    logic                    buf_free;
    logic                    buf_push;
    logic [PORT_WIDTH - 1:0] buf_addr;
    logic [PORT_WIDTH - 1:0] buf_data;
    mem_op_width_t           buf_width;

    dcache_port_if cache_if ();

    store_cache_control u_control (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .inval_req_i   (inval_req_i),
        .inval_addr_i  (inval_addr_i),
        .inval_ack_o   (inval_ack_o),
        .store_req_i   (store_req_i),
        .store_data_i  (store_data_i),
        .store_addr_i  (store_addr_i),
        .store_width_i (store_width_i),
        .cache         (cache_if.ctrl),
        .buf_free_i    (buf_free),
        .buf_push_o    (buf_push),
        .buf_addr_o    (buf_addr),
        .buf_data_o    (buf_data),
        .buf_width_o   (buf_width),
        .done_o        (done_o),
        .idle_o        (idle_o)
    );

    dcache_arrays #(
        .INDEX_BITS (INDEX_BITS)
    ) u_arrays (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cache       (cache_if.array),
        .fill_i      (fill_i),
        .fill_addr_i (fill_addr_i),
        .fill_data_i (fill_data_i),
        .load_addr_i (load_addr_i),
        .load_hit_o  (load_hit_o),
        .load_data_o (load_data_o)
    );

    store_buffer #(
        .DEPTH (BUF_DEPTH)
    ) u_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (buf_push),
        .addr_i      (buf_addr),
        .data_i      (buf_data),
        .width_i     (buf_width),
        .free_o      (buf_free),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_data_o  (mem_data_o),
        .mem_width_o (mem_width_o),
        .mem_ack_i   (mem_ack_i)
    );

endmodule : store_subsystem_top

`default_nettype wire

//--- test/tb_store_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_store_subsystem;
    import dcache_pkg::*;

    localparam int N_OPS          = 300;
    localparam int TIMEOUT_CYCLES = 40 * N_OPS;
    localparam int LINES          = 2 ** INDEX_BITS_DEFAULT;

    logic clk_i, rst_n_i, inval_req_i, store_req_i, fill_i, mem_ack_i;
    logic [31:0] inval_addr_i, store_data_i, store_addr_i, fill_addr_i, fill_data_i, load_addr_i;
    mem_op_width_t store_width_i;
    logic inval_ack_o, done_o, idle_o, load_hit_o, mem_req_o;
    logic [31:0] load_data_o, mem_addr_o, mem_data_o;
    mem_op_width_t mem_width_o;

    integer seed = 32'hfb1b;
    integer ack_seed = 32'hfb1b ^ 32'h0000_5a5a;        // Separate stream for the memory side
    int cycle_count = 0, done_count = 0, ack_count = 0;
    int req_count = 0, inval_count = 0, hit_count = 0, miss_count = 0;

    logic              m_valid [LINES];                  // Reference model of the cache
    logic [25:0]       m_tag   [LINES];
    logic [31:0]       m_data  [LINES];
    logic [65:0]       mem_q[$];                         // Expected memory writes {addr, data, width}

    store_subsystem_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [95:0] expected, input logic [95:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("** Error %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // Byte lanes follow byte_sel and half words follow byte_sel[1]
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [1:0] width, input logic [1:0] bsel);
        logic [31:0] res;
        res = old;
        case (width)
            2'd0: res[8 * bsel +: 8] = wdata[7:0];
            2'd1: res[16 * bsel[1] +: 16] = wdata[15:0];
            default: res = wdata;                        // Word and double word
        endcase
        return res;
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [25:0] tag;
        logic [5:0] low;
        tag = 26'($unsigned($random(seed)) % 3);        // Few tags so hits and misses mix
        low = 6'($random(seed));
        return {tag, low};
    endfunction

    function automatic logic model_hit(input logic [31:0] addr);
        return m_valid[addr[5:2]] && (m_tag[addr[5:2]] == addr[31:6]);
    endfunction

    task automatic verify_line(input logic [31:0] addr, input string name);
        logic exp_hit;
        exp_hit = model_hit(addr);
        @(posedge clk_i);
        load_addr_i <= addr;
        @(posedge clk_i);
        @(negedge clk_i);                                // Registered load result
        check({name, " load hit"}, exp_hit, load_hit_o);
        if (exp_hit) begin
            check({name, " load data"}, m_data[addr[5:2]], load_data_o);
        end
    endtask

    task automatic sweep_lines(input string name);
        logic [31:0] addr;
        for (int i = 0; i < LINES; i++) begin
            addr = {m_valid[i] ? m_tag[i] : 26'($unsigned($random(seed)) % 3), 4'(i), 2'b00};
            verify_line(addr, name);
        end
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk_i);
        end while (!done_o);
        @(posedge clk_i);
        store_req_i <= 1'b0;
        inval_req_i <= 1'b0;
        req_count++;
    endtask

    task automatic do_fill();
        logic [31:0] addr, data;
        addr = rand_addr();
        data = $random(seed);
        m_valid[addr[5:2]] = 1'b1;
        m_tag[addr[5:2]]   = addr[31:6];
        m_data[addr[5:2]]  = data;
        @(posedge clk_i);
        fill_i      <= 1'b1;
        fill_addr_i <= addr;
        fill_data_i <= data;
        @(posedge clk_i);
        fill_i      <= 1'b0;
        verify_line(addr, "fill");
    endtask

    task automatic do_store();
        logic [31:0] addr, data;
        logic [1:0] width;
        addr  = rand_addr();
        data  = $random(seed);
        width = 2'($random(seed));
        if (model_hit(addr)) begin
            m_data[addr[5:2]] = merge_store(m_data[addr[5:2]], data, width, addr[1:0]);
            hit_count++;
        end else begin
            mem_q.push_back({addr, data, width});        // Write-no-allocate
            miss_count++;
        end
        @(posedge clk_i);
        store_addr_i  <= addr;
        store_data_i  <= data;
        store_width_i <= mem_op_width_t'(width);
        store_req_i   <= 1'b1;
        wait_done();
        verify_line(addr, "store");
    endtask

    task automatic do_inval();
        logic [31:0] addr;
        addr = rand_addr();
        if (model_hit(addr)) begin
            m_valid[addr[5:2]] = 1'b0;
        end
        @(posedge clk_i);
        inval_addr_i <= addr;
        inval_req_i  <= 1'b1;
        inval_count++;
        wait_done();
        verify_line(addr, "inval");
    endtask

    always @(posedge clk_i) begin
        mem_ack_i <= rst_n_i && (($random(ack_seed) & 3) == 0);   // Mostly stalled memory
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // Memory writes and completion pulses sampled mid cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            done_count += done_o;
            ack_count  += inval_ack_o;
            if (mem_req_o && mem_ack_i) begin
                if (mem_q.size() == 0) begin
                    abort_run($sformatf("Memory write to %h was not expected", mem_addr_o));
                end else begin
                    check("memory write", mem_q.pop_front(), {mem_addr_o, mem_data_o, mem_width_o});
                end
            end
        end
    end

    initial begin
        int op;
        rst_n_i = 1'b0;
        inval_req_i = 1'b0;
        store_req_i = 1'b0;
        fill_i = 1'b0;
        mem_ack_i = 1'b0;
        inval_addr_i = '0;
        store_data_i = '0;
        store_addr_i = '0;
        store_width_i = WORD;
        fill_addr_i = '0;
        fill_data_i = '0;
        load_addr_i = '0;
        for (int i = 0; i < LINES; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check("reset idle", 1, idle_o);
        check("reset mem_req", 0, mem_req_o);
        sweep_lines("reset");
        for (int n = 0; n < N_OPS; n++) begin
            op = $unsigned($random(seed)) % 10;
            if (op < 3) begin
                do_fill();
            end else if (op < 8) begin
                do_store();
            end else begin
                do_inval();
            end
            if (n % 32 == 31) begin
                sweep_lines("sweep");
            end
        end
        sweep_lines("final");
        while (mem_q.size() != 0 || mem_req_o) begin    // Let the buffer drain
            @(negedge clk_i);
        end
        check("done count", req_count, done_count);
        check("inval ack count", inval_count, ack_count);
        if (hit_count == 0 || miss_count == 0) begin
            abort_run("Store hits and store misses were not both exercised");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule : tb_store_subsystem

`default_nettype wire

//--- build.f
verilog/dcache_pkg.sv
verilog/dcache_port_if.sv
verilog/store_cache_control.sv
verilog/dcache_arrays.sv
verilog/store_buffer.sv
verilog/store_subsystem_top.sv
test/tb_store_subsystem.sv

//--- Bender.yml
package:
  name: store_subsystem

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_port_if.sv
  - verilog/store_cache_control.sv
  - verilog/dcache_arrays.sv
  - verilog/store_buffer.sv
  - verilog/store_subsystem_top.sv
  - target: test
    files:
      - test/tb_store_subsystem.sv
